//--- hw/mem_request_issue.sv
`timescale 1ns/1ns
`default_nettype none

module mem_request_issue #(
    parameter int unsigned DEPTH = mrs_pkg::DEFAULT_DEPTH
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Request port from the upstream stage
    input  logic           req_valid_i,
    input  logic           req_walk_i,
    input  mrs_pkg::addr_t req_addr_i,
    input  mrs_pkg::tag_t  req_tag_i,
    output logic           req_ready_o,
    // Read request half of the memory port
    output logic           mem_req_o,
    output mrs_pkg::addr_t mem_addr_o,
    input  logic           mem_gnt_i,
    // One pulse per transaction leaving the stage
    input  logic           retire_i,
    // Accepted transactions toward the pending FIFO
    txn_if.producer        pend_in
);

    import mrs_pkg::*;

    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_WAIT_GNT
    } issue_state_e;

    issue_state_e state_q, state_d;
    credit_t      credit_q, credit_d;
    logic         credit_free;
    logic         accept;

    //////////////////////////////
    // Acceptance
    //////////////////////////////

    // Room for one more transaction inside the stage
    // Pending FIFO ready never drops while credits are left
    assign credit_free = (credit_q < credit_t'(DEPTH)) && pend_in.ready;

    always_comb begin
        state_d   = state_q;
        mem_req_o = 1'b0;
        accept    = 1'b0;
        case (state_q)
            ISSUE_IDLE: begin
                if (req_valid_i && credit_free) begin
                    if (req_walk_i) begin
                        // Read goes out now, accepted on the grant edge
                        mem_req_o = 1'b1;
                        accept    = mem_gnt_i;
                        if (!mem_gnt_i) begin
                            state_d = ISSUE_WAIT_GNT;
                        end
                    end else begin
                        // No memory access needed
                        accept = 1'b1;
                    end
                end
            end
            ISSUE_WAIT_GNT: begin
                // Request stays up until granted, address is held by upstream
                mem_req_o = 1'b1;
                accept    = mem_gnt_i;
                if (mem_gnt_i) begin
                    state_d = ISSUE_IDLE;
                end
            end
            default: begin
                state_d = ISSUE_IDLE;
            end
        endcase
    end

    assign req_ready_o = accept;
    assign mem_addr_o  = req_addr_i;

    // Forward the accepted transaction unchanged
    assign pend_in.valid = accept;
    assign pend_in.walk  = req_walk_i;
    assign pend_in.word  = req_addr_i;
    assign pend_in.tag   = req_tag_i;

    //////////////////////////////
    // Credits
    //////////////////////////////

    // Up on accept, down on retire, unchanged when both happen
    always_comb begin
        credit_d = credit_q;
        if (accept && !retire_i) begin
            credit_d = credit_q + credit_t'(1);
        end else if (!accept && retire_i) begin
            credit_d = credit_q - credit_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q  <= ISSUE_IDLE;
            credit_q <= '0;
        end else begin
            state_q  <= state_d;
            credit_q <= credit_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/memory_read_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_read_stage #(
    parameter int unsigned DEPTH = mrs_pkg::DEFAULT_DEPTH
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Request port
    input  logic           req_valid_i,
    output logic           req_ready_o,
    input  logic           req_walk_i,
    input  mrs_pkg::addr_t req_addr_i,
    input  mrs_pkg::tag_t  req_tag_i,
    // Memory port, read only
    output logic           mem_req_o,
    output mrs_pkg::addr_t mem_addr_o,
    input  logic           mem_gnt_i,
    input  logic           mem_rvalid_i,
    input  mrs_pkg::word_t mem_rdata_i,
    // Response port
    output logic           rsp_valid_o,
    input  logic           rsp_ready_i,
    output logic           rsp_walk_o,
    output mrs_pkg::addr_t rsp_data_o,
    output mrs_pkg::tag_t  rsp_tag_o
);

    import mrs_pkg::*;

    // Depth outside the supported range stops elaboration
    if (DEPTH < 2 || DEPTH > MAX_DEPTH) begin : g_depth_check
        $error("memory_read_stage: DEPTH must be between 2 and MAX_DEPTH");
    end

    txn_if pend_in ();
    txn_if pend_out ();
    txn_if merged ();
    txn_if rsp_out ();

    // A transaction leaves the stage and returns its credit
    logic retire;

    assign retire = rsp_valid_o && rsp_ready_i;

    //////////////////////////////
    // Pipeline
    //////////////////////////////

    mem_request_issue #(.DEPTH(DEPTH)) u_issue (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .req_walk_i  (req_walk_i),
        .req_addr_i  (req_addr_i),
        .req_tag_i   (req_tag_i),
        .req_ready_o (req_ready_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_gnt_i   (mem_gnt_i),
        .retire_i    (retire),
        .pend_in     (pend_in)
    );

    // Transactions waiting for their memory response
    txn_fifo #(.DEPTH(DEPTH)) u_pending_fifo (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push_side (pend_in),
        .pop_side  (pend_out)
    );

    response_merge #(.DEPTH(DEPTH)) u_merge (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .pend_out     (pend_out),
        .merged       (merged)
    );

    // Absorbs back-pressure from the response port
    txn_fifo #(.DEPTH(DEPTH)) u_output_fifo (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push_side (merged),
        .pop_side  (rsp_out)
    );

    assign rsp_out.ready = rsp_ready_i;
    assign rsp_valid_o   = rsp_out.valid;
    assign rsp_walk_o    = rsp_out.walk;
    assign rsp_data_o    = rsp_out.word;
    assign rsp_tag_o     = rsp_out.tag;

endmodule

`default_nettype wire

//--- hw/mrs_pkg.sv
`default_nettype none

package mrs_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    // Width of a memory address and of a data word
    localparam int unsigned ADDR_W = 32;

    // Width of the transaction identifier
    localparam int unsigned TAG_W = 8;

    // Largest depth the stage supports
    localparam int unsigned MAX_DEPTH = 16;

    // Default limit of transactions inside the stage and of FIFO entries
    localparam int unsigned DEFAULT_DEPTH = 4;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Pointer going out on the memory port
    // Also the payload of a non-walking transaction, which keeps its pointer
    typedef logic [ADDR_W-1:0] addr_t;

    // Read data returned by the memory
    typedef logic [ADDR_W-1:0] word_t;

    // Transaction identifier
    typedef logic [TAG_W-1:0] tag_t;

    // Occupancy or credit counter, holds 0 up to MAX_DEPTH
    typedef logic [$clog2(MAX_DEPTH):0] credit_t;

endpackage

`default_nettype wire

//--- hw/response_merge.sv
`timescale 1ns/1ns
`default_nettype none

module response_merge #(
    parameter int unsigned DEPTH = mrs_pkg::DEFAULT_DEPTH
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Read response half of the memory port
    input  logic           mem_rvalid_i,
    input  mrs_pkg::word_t mem_rdata_i,
    // Head of the pending FIFO
    txn_if.consumer        pend_out,
    // Completed transactions toward the output FIFO
    txn_if.producer        merged
);

    import mrs_pkg::*;

    localparam int unsigned PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    // Responses that came back before their transaction reached the head
    word_t   cap_mem [DEPTH];
    ptr_t    cap_wr_q;
    ptr_t    cap_rd_q;
    credit_t cap_count_q;

    logic    cap_empty;
    logic    rsp_avail;
    word_t   rsp_word;
    logic    head_ok;
    logic    pop;
    logic    use_rsp;
    logic    cap_push;
    logic    cap_pop;

    function automatic ptr_t ptr_next(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    //////////////////////////////
    // Head selection
    //////////////////////////////

    assign cap_empty = (cap_count_q == '0);
    // Oldest response is either buffered or on the bus right now
    assign rsp_avail = !cap_empty || mem_rvalid_i;
    assign rsp_word  = cap_empty ? mem_rdata_i : cap_mem[cap_rd_q];

    // Non-walking head never waits for memory
    assign head_ok = !pend_out.walk || rsp_avail;

    assign merged.valid = pend_out.valid && head_ok;
    assign merged.walk  = pend_out.walk;
    // Walking transaction has its pointer replaced by the read data
    assign merged.word  = pend_out.walk ? rsp_word : pend_out.word;
    assign merged.tag   = pend_out.tag;

    assign pend_out.ready = merged.ready && head_ok;

    assign pop     = pend_out.valid && pend_out.ready;
    assign use_rsp = pop && pend_out.walk;

    //////////////////////////////
    // Capture buffer
    //////////////////////////////

    // Bus response used in the same cycle bypasses the buffer
    assign cap_push = mem_rvalid_i && !(use_rsp && cap_empty);
    assign cap_pop  = use_rsp && !cap_empty;

    always_ff @(posedge clk_i) begin
        if (cap_push) begin
            cap_mem[cap_wr_q] <= mem_rdata_i;
        end
    end

    // Outstanding grants are bounded by DEPTH so the buffer never overflows
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cap_wr_q    <= '0;
            cap_rd_q    <= '0;
            cap_count_q <= '0;
        end else begin
            if (cap_push) begin
                cap_wr_q <= ptr_next(cap_wr_q);
            end
            if (cap_pop) begin
                cap_rd_q <= ptr_next(cap_rd_q);
            end
            case ({cap_push, cap_pop})
                2'b10:   cap_count_q <= cap_count_q + credit_t'(1);
                2'b01:   cap_count_q <= cap_count_q - credit_t'(1);
                default: cap_count_q <= cap_count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/txn_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module txn_fifo #(
    parameter int unsigned DEPTH = mrs_pkg::DEFAULT_DEPTH
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    // Write side
    txn_if.consumer push_side,
    // Read side, head of the queue
    txn_if.producer pop_side
);

    import mrs_pkg::*;

    localparam int unsigned PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    // Storage, one entry per transaction
    logic    walk_mem [DEPTH];
    addr_t   word_mem [DEPTH];
    tag_t    tag_mem  [DEPTH];

    ptr_t    wr_ptr_q;
    ptr_t    rd_ptr_q;
    credit_t count_q;
    logic    push;
    logic    pop;

    // Pointer increment with wrap for any depth
    function automatic ptr_t ptr_next(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    assign push_side.ready = (count_q < credit_t'(DEPTH));
    assign pop_side.valid  = (count_q != '0);

    assign push = push_side.valid && push_side.ready;
    assign pop  = pop_side.valid && pop_side.ready;

    // Head entry, registered so nothing falls through
    assign pop_side.walk = walk_mem[rd_ptr_q];
    assign pop_side.word = word_mem[rd_ptr_q];
    assign pop_side.tag  = tag_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            walk_mem[wr_ptr_q] <= push_side.walk;
            word_mem[wr_ptr_q] <= push_side.word;
            tag_mem[wr_ptr_q]  <= push_side.tag;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + credit_t'(1);
                2'b01:   count_q <= count_q - credit_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/txn_if.sv
`timescale 1ns/1ns
`default_nettype none

// Valid/ready channel carrying one transaction per transfer
interface txn_if;

    import mrs_pkg::*;

    logic  valid;
    logic  ready;
    // Set when the transaction reads memory
    logic  walk;
    // Pointer on the way in, read data on the way out
    addr_t word;
    tag_t  tag;

    // Side that offers transactions
    modport producer (
        output valid, walk, word, tag,
        input  ready
    );

    // Side that takes transactions
    modport consumer (
        input  valid, walk, word, tag,
        output ready
    );

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build from the file list, run, and look for the pass message in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f \
        --top-module tb_memory_read_stage -o tb_sim \
    && ./obj_dir/tb_sim +verilator+error+limit+100 | tee /dev/stderr \
        | grep -q "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb/memory_read_stage_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module memory_read_stage_asserts (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           req_ready_o,
    input  logic           mem_req_o,
    input  mrs_pkg::addr_t mem_addr_o,
    input  logic           mem_gnt_i,
    input  logic           rsp_valid_o,
    input  logic           rsp_ready_i,
    input  logic           rsp_walk_o,
    input  mrs_pkg::addr_t rsp_data_o,
    input  mrs_pkg::tag_t  rsp_tag_o
);

    // Failed assertions, read by the testbench at the end
    int unsigned fail_count = 0;

    // Memory request held with a stable address until the grant edge
    a_mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
        fail_count++;
        $error("mem_req_o dropped or mem_addr_o changed before the grant");
    end

    // Response held with its payload while the consumer stalls
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o
            && $stable({rsp_walk_o, rsp_data_o, rsp_tag_o}))
    else begin
        fail_count++;
        $error("rsp_valid_o or the response payload changed under back-pressure");
    end

    // Outputs quiet once reset has been seen for a cycle
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_ni && $past(!rst_ni) |-> !req_ready_o && !mem_req_o && !rsp_valid_o)
    else begin
        fail_count++;
        $error("handshake output high during reset");
    end

endmodule

bind memory_read_stage memory_read_stage_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_ready_o (req_ready_o),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_gnt_i   (mem_gnt_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_walk_o  (rsp_walk_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_tag_o   (rsp_tag_o)
);

`default_nettype wire

//--- tb/tb_memory_read_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_memory_read_stage;

    import mrs_pkg::*;

    localparam int unsigned DEPTH = DEFAULT_DEPTH;
    // Memory returns the address scrambled with this pattern
    localparam logic [31:0] MEM_XOR = 32'hA5A5_0F0F;
    // Transactions over all tests, 20 cycles allowed for each
    localparam int N_TXN = 1 + 1 + 20 + (DEPTH + 2) + 1;
    localparam int TIMEOUT = N_TXN * 20;

    // Grant and response-ready patterns
    localparam int MODE_ON = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_OFF = 2;

    logic  clk_i;
    logic  rst_ni;
    logic  req_valid_i;
    logic  req_ready_o;
    logic  req_walk_i;
    addr_t req_addr_i;
    tag_t  req_tag_i;
    logic  mem_req_o;
    addr_t mem_addr_o;
    logic  mem_gnt_i;
    logic  mem_rvalid_i;
    word_t mem_rdata_i;
    logic  rsp_valid_o;
    logic  rsp_ready_i;
    logic  rsp_walk_o;
    addr_t rsp_data_o;
    tag_t  rsp_tag_o;

    // Owned by the memory model and monitor
    int          cycle;
    int          accepted;
    int          received;
    int          rsp_errors;
    int          mem_req_cycles;
    int          last_due;
    logic [15:0] lfsr_mem;
    // Expected responses as {walk, tag, data}
    logic [40:0] exp_q[$];
    addr_t       rd_addr_q[$];
    int          rd_due_q[$];

    // Owned by the test sequence
    int          gnt_mode;
    int          rsp_mode;
    int          chk_errors;
    int          tests_failed;
    logic [15:0] lfsr_stim;

    memory_read_stage #(.DEPTH(DEPTH)) u_dut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_walk_i   (req_walk_i),
        .req_addr_i   (req_addr_i),
        .req_tag_i    (req_tag_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_walk_o   (rsp_walk_o),
        .rsp_data_o   (rsp_data_o),
        .rsp_tag_o    (rsp_tag_o)
    );

    //////////////////////////////
    // Random bits
    //////////////////////////////

    // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Request fields, one step per bit
    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_stim[0]};
            lfsr_stim = lfsr_next(lfsr_stim);
        end
        return v;
    endfunction

    // Grant pattern, read delays and response stalls
    function automatic logic [31:0] mem_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_mem[0]};
            lfsr_mem = lfsr_next(lfsr_mem);
        end
        return v;
    endfunction

    function automatic int error_total();
        return chk_errors + rsp_errors + int'(u_dut.u_asserts.fail_count);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAIL %s = 0x%h, expected 0x%h (cycle %0d)", name, got, want, cycle);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Memory model and monitor
    //////////////////////////////

    initial begin
        int          delay;
        int          due;
        logic [40:0] exp;
        cycle          = 0;
        accepted       = 0;
        received       = 0;
        rsp_errors     = 0;
        mem_req_cycles = 0;
        last_due       = 0;
        lfsr_mem       = 16'd48;
        mem_gnt_i      = 1'b0;
        mem_rvalid_i   = 1'b0;
        mem_rdata_i    = '0;
        rsp_ready_i    = 1'b0;
        forever begin
            @(posedge clk_i);
            cycle++;
            if (rst_ni) begin
                if (mem_req_o) begin
                    mem_req_cycles++;
                end
                // Granted read returns 1 to 3 cycles later, never overtaking
                if (mem_req_o && mem_gnt_i) begin
                    delay = 1 + int'(mem_bits(2) % 3);
                    due = cycle + delay - 1;
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    rd_addr_q.push_back(mem_addr_o);
                    rd_due_q.push_back(due);
                end
                // Scoreboard entry on acceptance
                if (req_valid_i && req_ready_o) begin
                    accepted++;
                    exp_q.push_back({req_walk_i, req_tag_i,
                                     req_walk_i ? (req_addr_i ^ MEM_XOR) : req_addr_i});
                end
                if (rsp_valid_o && rsp_ready_i) begin
                    received++;
                    if (exp_q.size() == 0) begin
                        $display("response with tag 0x%h arrived with nothing accepted",
                                 rsp_tag_o);
                        rsp_errors++;
                    end else begin
                        exp = exp_q.pop_front();
                        if (rsp_tag_o != exp[39:32]) begin
                            report_mismatch("rsp_tag_o", 32'(rsp_tag_o), 32'(exp[39:32]));
                            rsp_errors++;
                        end
                        if (rsp_walk_o != exp[40]) begin
                            report_mismatch("rsp_walk_o", 32'(rsp_walk_o), 32'(exp[40]));
                            rsp_errors++;
                        end
                        if (rsp_data_o != exp[31:0]) begin
                            report_mismatch("rsp_data_o", rsp_data_o, exp[31:0]);
                            rsp_errors++;
                        end
                    end
                end
            end
            @(negedge clk_i);
            case (gnt_mode)
                MODE_ON:     mem_gnt_i = 1'b1;
                MODE_RANDOM: mem_gnt_i = (mem_bits(1) != 0);
                default:     mem_gnt_i = 1'b0;
            endcase
            case (rsp_mode)
                MODE_ON:     rsp_ready_i = 1'b1;
                MODE_RANDOM: rsp_ready_i = (mem_bits(1) != 0);
                default:     rsp_ready_i = 1'b0;
            endcase
            // One response pulse per cycle at most, in grant order
            mem_rvalid_i = 1'b0;
            if (rd_due_q.size() != 0) begin
                if (rd_due_q[0] <= cycle) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = rd_addr_q.pop_front() ^ MEM_XOR;
                    due          = rd_due_q.pop_front();
                end
            end
        end
    end

    initial begin
        while (cycle < TIMEOUT) begin
            @(posedge clk_i);
        end
        $display("timeout after %0d cycles with %0d responses missing", cycle, exp_q.size());
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////
    // Test helpers
    //////////////////////////////

    // Hold the request until the accepting edge
    task automatic issue_req(input logic walk, input addr_t addr, input tag_t tag);
        @(negedge clk_i);
        req_valid_i = 1'b1;
        req_walk_i  = walk;
        req_addr_i  = addr;
        req_tag_i   = tag;
        @(posedge clk_i);
        while (!req_ready_o) begin
            @(posedge clk_i);
        end
    endtask

    task automatic idle_and_drain();
        @(negedge clk_i);
        req_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;
        errs = error_total() - errs_before;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_single_walk();
        int errs;
        int req_cycles;
        errs = error_total();
        req_cycles = mem_req_cycles;
        issue_req(1'b1, 32'h0000_1000, 8'h01);
        idle_and_drain();
        // Grant is always on here, so the read is requested for one cycle only
        if (mem_req_cycles != req_cycles + 1) begin
            $display("single walk held mem_req_o for %0d cycles instead of one",
                     mem_req_cycles - req_cycles);
            chk_errors++;
        end
        finish_test("single_walk", errs);
    endtask

    task automatic test_single_plain();
        int errs;
        int req_cycles;
        errs = error_total();
        req_cycles = mem_req_cycles;
        issue_req(1'b0, 32'h0000_2000, 8'h02);
        idle_and_drain();
        if (mem_req_cycles != req_cycles) begin
            $display("mem_req_o rose for a request that does not walk");
            chk_errors++;
        end
        finish_test("single_plain", errs);
    endtask

    // Non-walking entries make responses land while such a head waits
    task automatic test_mixed_stream();
        int    errs;
        logic  walk;
        addr_t addr;
        errs = error_total();
        gnt_mode = MODE_RANDOM;
        rsp_mode = MODE_RANDOM;
        for (int i = 0; i < 20; i++) begin
            walk = (stim_bits(2) != 0);
            addr = stim_bits(20) << 2;
            issue_req(walk, addr, tag_t'(32 + i));
        end
        idle_and_drain();
        @(posedge clk_i);
        gnt_mode = MODE_ON;
        rsp_mode = MODE_ON;
        finish_test("mixed_stream", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        int acc;
        errs = error_total();
        acc = accepted;
        rsp_mode = MODE_OFF;
        fork
            begin
                for (int i = 0; i < DEPTH + 2; i++) begin
                    issue_req(i[0], 32'h0000_4000 + 32'(i * 4), tag_t'(64 + i));
                end
            end
            begin
                repeat (40) @(negedge clk_i);
                // Credits bound what gets in while nothing drains
                if (accepted - acc != DEPTH) begin
                    report_mismatch("accepted requests", 32'(accepted - acc), 32'(DEPTH));
                    chk_errors++;
                end
                if (req_ready_o != 1'b0) begin
                    report_mismatch("req_ready_o", 32'(req_ready_o), 32'h0);
                    chk_errors++;
                end
                @(posedge clk_i);
                rsp_mode = MODE_ON;
            end
        join
        idle_and_drain();
        finish_test("back_pressure", errs);
    endtask

    task automatic test_held_request();
        int errs;
        errs = error_total();
        gnt_mode = MODE_OFF;
        fork
            issue_req(1'b1, 32'h0000_5000, 8'h50);
            begin
                // First look is one cycle after the request goes up
                @(posedge clk_i);
                repeat (5) begin
                    @(negedge clk_i);
                    if (mem_req_o != 1'b1) begin
                        report_mismatch("mem_req_o", 32'(mem_req_o), 32'h1);
                        chk_errors++;
                    end
                    if (mem_addr_o != 32'h0000_5000) begin
                        report_mismatch("mem_addr_o", mem_addr_o, 32'h0000_5000);
                        chk_errors++;
                    end
                    if (req_ready_o != 1'b0) begin
                        report_mismatch("req_ready_o", 32'(req_ready_o), 32'h0);
                        chk_errors++;
                    end
                end
                @(posedge clk_i);
                gnt_mode = MODE_ON;
            end
        join
        idle_and_drain();
        finish_test("held_request", errs);
    endtask

    initial begin
        rst_ni       = 1'b0;
        req_valid_i  = 1'b0;
        req_walk_i   = 1'b0;
        req_addr_i   = '0;
        req_tag_i    = '0;
        gnt_mode     = MODE_ON;
        rsp_mode     = MODE_ON;
        chk_errors   = 0;
        tests_failed = 0;
        lfsr_stim    = 16'd48;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        test_single_walk();
        test_single_plain();
        test_mixed_stream();
        test_back_pressure();
        test_held_request();

        $display("tests 5, failed %0d, errors %0d, responses %0d",
                 tests_failed, error_total(), received);
        if (error_total() == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/mrs_pkg.sv
hw/txn_if.sv
hw/mem_request_issue.sv
hw/txn_fifo.sv
hw/response_merge.sv
hw/memory_read_stage.sv
tb/memory_read_stage_asserts.sv
tb/tb_memory_read_stage.sv
